// ==== gfx_pattern_demo.f ====
+incdir+logic
+incdir+verification
logic/gfx_pkg.sv
logic/vga_pkg.sv
logic/gfx_stream_if.sv
logic/gfx_pattern.sv
logic/fb_ram.sv
logic/fb_scanout.sv
logic/pix_vga.sv
logic/gfx_pattern_demo.sv
verification/gfx_pattern_demo_tb.sv

// ==== logic/fb_ram.sv ====
`include "gfx_macros.svh"

module fb_ram (
  input  logic              clk,
  gfx_stream_if.sink        draw,
  input  logic              rd_req,
  input  gfx_pkg::fb_addr_t rd_addr,
  output gfx_pkg::pixel_t   rd_data
);
  import gfx_pkg::*;

  pixel_t   mem [`FB_DEPTH];
  fb_addr_t wr_addr;
  logic     wr_en;

  // reads win the single port, draw writes wait
  assign draw.ready = !rd_req;
  assign wr_en      = draw.valid && draw.ready;

  // raster address, y * width + x
  assign wr_addr = fb_addr_t'(draw.data.y * `VGA_H_VISIBLE + draw.data.x);

  always_ff @(posedge clk) begin
    if (rd_req) begin
      rd_data <= mem[rd_addr];
    end else if (wr_en) begin
      mem[wr_addr] <= draw.data.pixel;
    end
  end

endmodule

// ==== logic/fb_scanout.sv ====
`include "gfx_macros.svh"

module fb_scanout (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              enable,
  output logic              rd_req,
  output gfx_pkg::fb_addr_t rd_addr,
  input  gfx_pkg::pixel_t   rd_data,
  gfx_stream_if.source      pix
);
  import gfx_pkg::*;

  localparam fb_addr_t ADDR_LAST = fb_addr_t'(`FB_DEPTH - 1);

  pixel_t     buf_mem [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;
  logic       rd_pend;
  logic [1:0] level;
  logic       push;
  logic       pop;

  // rd_data is valid the cycle after a request
  assign push = rd_pend;
  assign pop  = pix.valid && pix.ready;

  // entries held plus the read in flight
  assign level = count + 2'(rd_pend);

  // a pop this cycle frees the slot the new read will land in
  assign rd_req = enable && ((level < 2'd2) || pop);

  assign pix.valid = (count != 2'd0);
  assign pix.data  = buf_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      buf_mem[wr_ptr] <= rd_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr  <= 1'b0;
      rd_ptr  <= 1'b0;
      count   <= '0;
      rd_pend <= 1'b0;
      rd_addr <= '0;
    end else begin
      rd_pend <= rd_req;
      if (rd_req) begin
        // wrap so every frame rereads the same image
        rd_addr <= (rd_addr == ADDR_LAST) ? '0 : rd_addr + 1'b1;
      end
      if (push) begin
        wr_ptr <= ~wr_ptr;
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
      end
      count <= count + 2'(push) - 2'(pop);
    end
  end

endmodule

// ==== logic/gfx_macros.svh ====
`ifndef GFX_MACROS_SVH
`define GFX_MACROS_SVH

// colour channel and coordinate widths
`define GFX_COLOR_WIDTH 4
`define GFX_H_WIDTH 5
`define GFX_V_WIDTH 4

// horizontal timing in clocks, last count of a line is VGA_H_LINE_END
`define VGA_H_VISIBLE 16
`define VGA_H_SYNC_START 18
`define VGA_H_SYNC_END 22
`define VGA_H_LINE_END 25

// vertical timing in lines
`define VGA_V_VISIBLE 12
`define VGA_V_SYNC_START 13
`define VGA_V_SYNC_END 15
`define VGA_V_FRAME_END 16

`define FB_DEPTH (`VGA_H_VISIBLE * `VGA_V_VISIBLE)

`endif

// ==== logic/gfx_pattern.sv ====
`include "gfx_macros.svh"

module gfx_pattern (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         start,
  output logic         done,
  gfx_stream_if.source draw
);
  import gfx_pkg::*;

  localparam coord_x_t X_LAST = coord_x_t'(`VGA_H_VISIBLE - 1);
  localparam coord_y_t Y_LAST = coord_y_t'(`VGA_V_VISIBLE - 1);

  coord_x_t x;
  coord_y_t y;
  logic     busy;
  logic     xfer;
  pixel_t   pix;

  assign xfer = busy && draw.ready;

  // pattern rule
  assign pix.red = color_t'(x);
  assign pix.grn = color_t'(y << 2);
  assign pix.blu = pix.red ^ pix.grn;

  assign draw.valid = busy;
  assign draw.data  = '{x: x, y: y, pixel: pix};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy <= 1'b0;
      done <= 1'b0;
      x    <= '0;
      y    <= '0;
    end else if (start) begin
      busy <= 1'b1;
      done <= 1'b0;
      x    <= '0;
      y    <= '0;
    end else if (xfer) begin
      if (x == X_LAST) begin
        x <= '0;
        if (y == Y_LAST) begin
          // last write accepted
          busy <= 1'b0;
          done <= 1'b1;
        end else begin
          y <= y + 1'b1;
        end
      end else begin
        x <= x + 1'b1;
      end
    end
  end

endmodule

// ==== logic/gfx_pattern_demo.sv ====
`include "gfx_macros.svh"

module gfx_pattern_demo (
  input  logic                        clk,
  input  logic                        rst_n,
  output logic [`GFX_COLOR_WIDTH-1:0] vga_red,
  output logic [`GFX_COLOR_WIDTH-1:0] vga_grn,
  output logic [`GFX_COLOR_WIDTH-1:0] vga_blu,
  output logic                        vga_hsync,
  output logic                        vga_vsync,
  output logic                        vga_error,
  output logic                        fb_done
);
  import gfx_pkg::*;

  logic     start;
  logic     rd_req;
  fb_addr_t rd_addr;
  pixel_t   rd_data;

  gfx_stream_if #(.payload_t(gfx_wr_t)) draw_if ();
  gfx_stream_if #(.payload_t(pixel_t)) pix_if ();

  // held during reset, so it pulses on the first cycle out of reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      start <= 1'b1;
    end else begin
      start <= 1'b0;
    end
  end

  gfx_pattern gfx_pattern_i (
    .clk  (clk),
    .rst_n(rst_n),
    .start(start),
    .done (fb_done),
    .draw (draw_if.source)
  );

  fb_ram fb_ram_i (
    .clk    (clk),
    .draw   (draw_if.sink),
    .rd_req (rd_req),
    .rd_addr(rd_addr),
    .rd_data(rd_data)
  );

  // scanout only runs once the image is complete
  fb_scanout fb_scanout_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .enable (fb_done),
    .rd_req (rd_req),
    .rd_addr(rd_addr),
    .rd_data(rd_data),
    .pix    (pix_if.source)
  );

  pix_vga pix_vga_i (
    .clk  (clk),
    .rst_n(rst_n),
    .pix  (pix_if.sink),
    .hsync(vga_hsync),
    .vsync(vga_vsync),
    .red  (vga_red),
    .grn  (vga_grn),
    .blu  (vga_blu),
    .error(vga_error)
  );

endmodule

// ==== logic/gfx_pkg.sv ====
`include "gfx_macros.svh"

package gfx_pkg;

  typedef logic [`GFX_COLOR_WIDTH-1:0] color_t;
  typedef logic [`GFX_H_WIDTH-1:0] coord_x_t;
  typedef logic [`GFX_V_WIDTH-1:0] coord_y_t;

  typedef struct packed {
    color_t red;
    color_t grn;
    color_t blu;
  } pixel_t;

  // one draw write, the framebuffer derives the address itself
  typedef struct packed {
    coord_x_t x;
    coord_y_t y;
    pixel_t   pixel;
  } gfx_wr_t;

  typedef logic [$clog2(`FB_DEPTH)-1:0] fb_addr_t;

endpackage

// ==== logic/gfx_stream_if.sv ====
// valid/ready stream, a transfer happens when both are high at a clock edge
interface gfx_stream_if #(
  parameter type payload_t = logic
) ();

  logic     valid;
  logic     ready;
  payload_t data;

  modport source(
    output valid,
    output data,
    input  ready
  );

  modport sink(
    input  valid,
    input  data,
    output ready
  );

endinterface

// ==== logic/pix_vga.sv ====
`include "gfx_macros.svh"

module pix_vga (
  input  logic                        clk,
  input  logic                        rst_n,
  gfx_stream_if.sink                  pix,
  output logic                        hsync,
  output logic                        vsync,
  output logic [`GFX_COLOR_WIDTH-1:0] red,
  output logic [`GFX_COLOR_WIDTH-1:0] grn,
  output logic [`GFX_COLOR_WIDTH-1:0] blu,
  output logic                        error
);
  import vga_pkg::*;

  localparam h_cnt_t H_VISIBLE    = h_cnt_t'(`VGA_H_VISIBLE);
  localparam h_cnt_t H_SYNC_START = h_cnt_t'(`VGA_H_SYNC_START);
  localparam h_cnt_t H_SYNC_END   = h_cnt_t'(`VGA_H_SYNC_END);
  localparam h_cnt_t H_LINE_END   = h_cnt_t'(`VGA_H_LINE_END);
  localparam v_cnt_t V_VISIBLE    = v_cnt_t'(`VGA_V_VISIBLE);
  localparam v_cnt_t V_SYNC_START = v_cnt_t'(`VGA_V_SYNC_START);
  localparam v_cnt_t V_SYNC_END   = v_cnt_t'(`VGA_V_SYNC_END);
  localparam v_cnt_t V_FRAME_END  = v_cnt_t'(`VGA_V_FRAME_END);

  raster_state_e state;
  vga_pos_t      pos;
  logic          running;
  logic          visible;
  logic          h_sync_on;
  logic          v_sync_on;

  assign running   = (state == RASTER_RUN);
  assign visible   = running && (pos.h < H_VISIBLE) && (pos.v < V_VISIBLE);
  assign h_sync_on = running && (pos.h >= H_SYNC_START) && (pos.h < H_SYNC_END);
  assign v_sync_on = running && (pos.v >= V_SYNC_START) && (pos.v < V_SYNC_END);

  // one pixel per visible position
  assign pix.ready = visible;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= RASTER_IDLE;
      pos   <= '0;
    end else if (!running) begin
      // start the raster once the first pixel is waiting
      if (pix.valid) begin
        state <= RASTER_RUN;
      end
      pos <= '0;
    end else if (pos.h == H_LINE_END) begin
      pos.h <= '0;
      pos.v <= (pos.v == V_FRAME_END) ? '0 : pos.v + 1'b1;
    end else begin
      pos.h <= pos.h + 1'b1;
    end
  end

  // outputs trail the position by one clock
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hsync <= 1'b1;
      vsync <= 1'b1;
      red   <= '0;
      grn   <= '0;
      blu   <= '0;
      error <= 1'b0;
    end else begin
      hsync <= !h_sync_on;
      vsync <= !v_sync_on;
      if (visible && pix.valid) begin
        red <= pix.data.red;
        grn <= pix.data.grn;
        blu <= pix.data.blu;
      end else begin
        red <= '0;
        grn <= '0;
        blu <= '0;
      end
      // underflow is sticky
      if (visible && !pix.valid) begin
        error <= 1'b1;
      end
    end
  end

endmodule

// ==== logic/vga_pkg.sv ====
`include "gfx_macros.svh"

package vga_pkg;

  localparam int H_CNT_WIDTH = $clog2(`VGA_H_LINE_END + 1);
  localparam int V_CNT_WIDTH = $clog2(`VGA_V_FRAME_END + 1);

  typedef logic [H_CNT_WIDTH-1:0] h_cnt_t;
  typedef logic [V_CNT_WIDTH-1:0] v_cnt_t;

  typedef struct packed {
    h_cnt_t h;
    v_cnt_t v;
  } vga_pos_t;

  // idle waits for the first pixel before the raster starts
  typedef enum logic {RASTER_IDLE, RASTER_RUN} raster_state_e;

endpackage

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module gfx_pattern_demo_tb -Mdir obj_dir \
  -f gfx_pattern_demo.f \
  && ./obj_dir/Vgfx_pattern_demo_tb > sim.log 2>&1
grep -q "^Test OK$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

// ==== verification/gfx_pattern_demo_tb_checks.svh ====
`ifndef GFX_PATTERN_DEMO_TB_CHECKS_SVH
`define GFX_PATTERN_DEMO_TB_CHECKS_SVH

// expected colour of a coordinate
function automatic pixel_t pattern_pixel(int x, int y);
  pixel_t p;
  p.red = color_t'(x & ((1 << `GFX_COLOR_WIDTH) - 1));
  p.grn = color_t'((y << 2) & ((1 << `GFX_COLOR_WIDTH) - 1));
  p.blu = p.red ^ p.grn;
  return p;
endfunction

// raster step, h first then v
function automatic vga_pos_t next_pos(vga_pos_t p);
  vga_pos_t n;
  n = p;
  if (int'(p.h) == `VGA_H_LINE_END) begin
    n.h = '0;
    n.v = (int'(p.v) == `VGA_V_FRAME_END) ? '0 : p.v + 1'b1;
  end else begin
    n.h = p.h + 1'b1;
  end
  return n;
endfunction

// a vsync pulse opens at the start of its first line
function automatic vga_pos_t vsync_fall_pos();
  vga_pos_t p;
  p.h = '0;
  p.v = v_cnt_t'(`VGA_V_SYNC_START);
  return p;
endfunction

function automatic logic in_visible(vga_pos_t p);
  return (int'(p.h) < `VGA_H_VISIBLE) && (int'(p.v) < `VGA_V_VISIBLE);
endfunction

// syncs are active low
function automatic logic hsync_level(vga_pos_t p);
  return !((int'(p.h) >= `VGA_H_SYNC_START) && (int'(p.h) < `VGA_H_SYNC_END));
endfunction

function automatic logic vsync_level(vga_pos_t p);
  return !((int'(p.v) >= `VGA_V_SYNC_START) && (int'(p.v) < `VGA_V_SYNC_END));
endfunction

task automatic check_pixel(string name, pixel_t got, pixel_t exp);
  if (got !== exp) begin
    $display("CHECK FAILED %s: got 0x%03h expected 0x%03h", name, got, exp);
    errors++;
  end
endtask

task automatic check_bit(string name, logic got, logic exp);
  if (got !== exp) begin
    $display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
    errors++;
  end
endtask

task automatic check_pos(string name, vga_pos_t got, vga_pos_t exp);
  if (got !== exp) begin
    $display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
    errors++;
  end
endtask

task automatic check_count(string name, int got, int exp);
  if (got != exp) begin
    $display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
    errors++;
  end
endtask

task automatic report_timeout(string what);
  $display("timeout: %s", what);
  errors++;
endtask

`endif

// ==== verification/gfx_pattern_demo_tb.sv ====
`include "gfx_macros.svh"

module gfx_pattern_demo_tb;
  import gfx_pkg::*;
  import vga_pkg::*;

  localparam int LINE_CLKS    = `VGA_H_LINE_END + 1;
  localparam int FRAME_LINES  = `VGA_V_FRAME_END + 1;
  localparam int FRAME_CLKS   = LINE_CLKS * FRAME_LINES;
  localparam int FILL_TIMEOUT = 4 * `FB_DEPTH;
  localparam int RESET_CYCLES = 16;

  logic                        clk;
  logic                        rst_n;
  logic [`GFX_COLOR_WIDTH-1:0] vga_red;
  logic [`GFX_COLOR_WIDTH-1:0] vga_grn;
  logic [`GFX_COLOR_WIDTH-1:0] vga_blu;
  logic                        vga_hsync;
  logic                        vga_vsync;
  logic                        vga_error;
  logic                        fb_done;

  int errors;
  int tests_passed;
  int tests_failed;
  int test_first_error;

  `include "gfx_pattern_demo_tb_checks.svh"

  gfx_pattern_demo gfx_pattern_demo_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .vga_red  (vga_red),
    .vga_grn  (vga_grn),
    .vga_blu  (vga_blu),
    .vga_hsync(vga_hsync),
    .vga_vsync(vga_vsync),
    .vga_error(vga_error),
    .fb_done  (fb_done)
  );

  always #50 clk = ~clk;

  task automatic start_test();
    test_first_error = errors;
  endtask

  task automatic finish_test(string name);
    if (errors == test_first_error) begin
      tests_passed++;
      $display("PASS  %s", name);
    end else begin
      tests_failed++;
      $display("FAIL  %s (%0d errors)", name, errors - test_first_error);
    end
  endtask

  task automatic check_reset_outputs();
    check_pixel("{vga_red,vga_grn,vga_blu}", {vga_red, vga_grn, vga_blu}, '0);
    check_bit("vga_hsync", vga_hsync, 1'b1);
    check_bit("vga_vsync", vga_vsync, 1'b1);
    check_bit("vga_error", vga_error, 1'b0);
    check_bit("fb_done", fb_done, 1'b0);
  endtask

  task automatic wait_vsync_fall(output bit found);
    logic prev;
    int   n;
    found = 1'b0;
    prev  = vga_vsync;
    for (n = 0; n < 2 * FRAME_CLKS && !found; n++) begin
      @(negedge clk);
      if (prev === 1'b1 && vga_vsync === 1'b0) begin
        found = 1'b1;
      end
      prev = vga_vsync;
    end
    if (!found) begin
      report_timeout("no falling edge seen on vga_vsync");
    end
  endtask

  task automatic test_reset_state(string name);
    int n;
    start_test();
    @(posedge clk);
    rst_n <= 1'b0;
    // first edge after the drive still shows the old state
    @(negedge clk);
    for (n = 1; n < RESET_CYCLES; n++) begin
      @(negedge clk);
      check_reset_outputs();
    end
    @(posedge clk);
    rst_n <= 1'b1;
    repeat (4) begin
      @(negedge clk);
      check_reset_outputs();
    end
    finish_test(name);
  endtask

  task automatic test_fill(string name);
    int n;
    start_test();
    n = 0;
    while (fb_done !== 1'b1 && n < FILL_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (fb_done !== 1'b1) begin
      report_timeout("fb_done never rose after reset");
    end else begin
      repeat (LINE_CLKS) begin
        @(negedge clk);
        check_bit("fb_done", fb_done, 1'b1);
      end
    end
    finish_test(name);
  endtask

  task automatic test_sync(string name);
    vga_pos_t model;
    vga_pos_t edge_pos;
    logic     prev_h;
    logic     prev_v;
    bit       found;
    int       n;
    int       hfall_at;
    int       hlines;
    int       vfalls;
    start_test();
    wait_vsync_fall(found);
    if (found) begin
      model    = vsync_fall_pos();
      prev_h   = vga_hsync;
      prev_v   = vga_vsync;
      hfall_at = -1;
      hlines   = 0;
      vfalls   = 0;
      for (n = 1; n <= 2 * FRAME_CLKS; n++) begin
        @(negedge clk);
        model = next_pos(model);
        if (prev_h === 1'b1 && vga_hsync === 1'b0) begin
          if (hfall_at >= 0) begin
            check_count("clocks between hsync falls", n - hfall_at, LINE_CLKS);
          end
          hfall_at   = n;
          edge_pos.h = h_cnt_t'(`VGA_H_SYNC_START);
          edge_pos.v = v_cnt_t'((`VGA_V_SYNC_START + hlines) % FRAME_LINES);
          check_pos("position at hsync fall", model, edge_pos);
          hlines++;
        end
        if (prev_h === 1'b0 && vga_hsync === 1'b1 && hfall_at >= 0) begin
          check_count("hsync low clocks", n - hfall_at, `VGA_H_SYNC_END - `VGA_H_SYNC_START);
        end
        if (prev_v === 1'b1 && vga_vsync === 1'b0) begin
          check_count("lines between vsync falls", hlines, FRAME_LINES);
          check_pos("position at vsync fall", model, vsync_fall_pos());
          hlines = 0;
          vfalls++;
        end
        if (prev_v === 1'b0 && vga_vsync === 1'b1) begin
          check_count("vsync low lines", hlines, `VGA_V_SYNC_END - `VGA_V_SYNC_START);
        end
        prev_h = vga_hsync;
        prev_v = vga_vsync;
      end
      // the window ends exactly on the second following vsync fall
      check_count("vsync falls in two frames", vfalls, 2);
    end
    finish_test(name);
  endtask

  task automatic test_frames(string name);
    vga_pos_t pos;
    pixel_t   exp;
    bit       found;
    int       n;
    start_test();
    wait_vsync_fall(found);
    if (found) begin
      pos = vsync_fall_pos();
      for (n = 0; n < 2 * FRAME_CLKS; n++) begin
        @(negedge clk);
        pos = next_pos(pos);
        if (in_visible(pos)) begin
          exp = pattern_pixel(int'(pos.h), int'(pos.v));
        end else begin
          exp = '0;
        end
        check_pixel($sformatf("{vga_red,vga_grn,vga_blu} at (%0d,%0d)", pos.h, pos.v),
                    {vga_red, vga_grn, vga_blu}, exp);
        check_bit("vga_hsync", vga_hsync, hsync_level(pos));
        check_bit("vga_vsync", vga_vsync, vsync_level(pos));
        check_bit("fb_done", fb_done, 1'b1);
      end
    end
    finish_test(name);
  endtask

  task automatic test_no_underflow(string name);
    start_test();
    repeat (3 * FRAME_CLKS) begin
      @(negedge clk);
      check_bit("vga_error", vga_error, 1'b0);
    end
    finish_test(name);
  endtask

  initial begin
    int mid_wait;
    clk              = 1'b0;
    rst_n            = 1'b0;
    errors           = 0;
    tests_passed     = 0;
    tests_failed     = 0;
    test_first_error = 0;
    void'($urandom(16));
    test_reset_state("reset state");
    test_fill("fill completes");
    test_sync("sync structure");
    test_frames("frame content");
    test_no_underflow("no underflow");
    // second reset lands somewhere inside a frame
    mid_wait = 1 + int'($urandom % FRAME_CLKS);
    repeat (mid_wait) @(negedge clk);
    test_reset_state("reset mid-frame");
    test_fill("fill after reset");
    test_sync("sync after reset");
    test_frames("frame content after reset");
    $display("summary: %0d tests passed, %0d failed, %0d check errors",
             tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
